//--- backendPkg.sv
package backendPkg;

    // machine sizing.
    localparam int ALU_SIZE = 4;
    localparam int ROB_SIZE = 16;
    localparam int XLEN = 32;
    localparam int REG_IDX_W = 5;

    // multiplier bits retired per cycle.
    localparam int MUL_STEP = 8;
    localparam int MUL_CYCLES = XLEN / MUL_STEP;

    localparam int ROB_IDX_W = $clog2(ROB_SIZE);
    localparam int LANE_IDX_W = $clog2(ALU_SIZE);
    localparam int MUL_CNT_W = $clog2(MUL_CYCLES);

    typedef logic [XLEN-1:0] Word;

    typedef logic [ROB_IDX_W-1:0] RobIdx;

    // one extra bit so a full buffer can be told apart from an empty one.
    typedef logic [ROB_IDX_W:0] RobCount;

    typedef logic [REG_IDX_W-1:0] RegIdx;

    typedef logic [ALU_SIZE-1:0] LaneMask;

    typedef logic [LANE_IDX_W-1:0] LaneIdx;

    typedef logic [MUL_CNT_W-1:0] MulCount;

    // slice of the multiplier consumed in one step.
    typedef logic [MUL_STEP-1:0] MulDigit;

endpackage

//--- uopPkg.sv
package uopPkg;

    // encodings are fixed, the stimulus file uses them directly.
    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLT = 3'd5,
        MUL = 3'd6
    } AluOp;

    typedef enum logic {
        IDLE    = 1'b0,
        MULBUSY = 1'b1
    } LaneState;

    // decoded micro-op with its operand values already resolved.
    typedef struct packed {
        AluOp              op;
        backendPkg::RegIdx rd;
        backendPkg::Word   srcA;
        backendPkg::Word   srcB;
    } MicroOp;

    typedef struct packed {
        MicroOp            uop;
        backendPkg::RobIdx robIdx;
    } IssueBundle;

    typedef struct packed {
        backendPkg::RobIdx robIdx;
        backendPkg::RegIdx rd;
        backendPkg::Word   result;
    } WbBundle;

    // one retired result, leaving in program order.
    typedef struct packed {
        backendPkg::RobIdx robIdx;
        backendPkg::RegIdx rd;
        backendPkg::Word   value;
    } CommitBundle;

endpackage

//--- Dispatch.sv
`timescale 1ns/1ps

module Dispatch (
    input  logic                clk,
    input  logic                rstN,
    input  logic                uopValid,
    input  uopPkg::MicroOp      uop,
    input  backendPkg::LaneMask laneBusy,
    input  logic                robFull,
    input  backendPkg::RobIdx   allocIdx,
    output logic                stall,
    output logic                alloc,
    output backendPkg::LaneMask issueValid,
    output uopPkg::IssueBundle  issue
);

    backendPkg::LaneMask occupied;
    backendPkg::LaneIdx  rrPtr;
    backendPkg::LaneIdx  pick;
    logic                accept;

    // a lane being issued to right now has not raised busy yet.
    assign occupied = laneBusy | issueValid;

    assign stall = robFull || (&occupied);
    assign accept = uopValid && !stall;

    // the tail index is taken by this op, so the buffer advances now.
    assign alloc = accept;

    // first free lane at or after the round-robin pointer.
    always_comb begin : pickLane
        backendPkg::LaneIdx idx;
        logic               found;
        pick = rrPtr;
        found = 1'b0;
        for (int i = 0; i < backendPkg::ALU_SIZE; i++) begin
            idx = rrPtr + backendPkg::LaneIdx'(i);
            if (!found && !occupied[idx]) begin
                pick = idx;
                found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            issueValid <= '0;
            rrPtr <= '0;
        end else begin
            if (accept) begin
                issueValid <= backendPkg::LaneMask'(1) << pick;
                rrPtr <= pick + backendPkg::LaneIdx'(1);
            end else begin
                issueValid <= '0;
            end
        end
    end

    // shared issue payload, every lane sees it but only the masked one starts.
    always_ff @(posedge clk) begin
        if (accept) begin
            issue.uop <= uop;
            issue.robIdx <= allocIdx;
        end
    end

endmodule

//--- AluLane.sv
`timescale 1ns/1ps

module AluLane (
    input  logic               clk,
    input  logic               rstN,
    input  logic               start,
    input  uopPkg::IssueBundle issue,
    output logic               busy,
    output logic               wbValid,
    output uopPkg::WbBundle    wb
);

    uopPkg::LaneState    state;
    backendPkg::MulCount stepCnt;
    backendPkg::Word     acc;
    backendPkg::Word     mulA;
    backendPkg::Word     mulB;
    backendPkg::Word     partial;
    backendPkg::RobIdx   tagIdx;
    backendPkg::RegIdx   tagRd;
    logic                startMul;

    function automatic backendPkg::Word aluCompute(
        input uopPkg::AluOp    op,
        input backendPkg::Word a,
        input backendPkg::Word b
    );
        case (op)
            uopPkg::ADD: aluCompute = a + b;
            uopPkg::SUB: aluCompute = a - b;
            uopPkg::AND: aluCompute = a & b;
            uopPkg::OR:  aluCompute = a | b;
            uopPkg::XOR: aluCompute = a ^ b;
            uopPkg::SLT: aluCompute = backendPkg::Word'($signed(a) < $signed(b));
            default:     aluCompute = '0;
        endcase
    endfunction

    // one shifted partial product, upper bits fall off the word.
    function automatic backendPkg::Word stepProduct(
        input backendPkg::Word     a,
        input backendPkg::MulDigit digit
    );
        stepProduct = a * backendPkg::Word'(digit);
    endfunction

    assign startMul = start && (issue.uop.op == uopPkg::MUL);
    assign partial = stepProduct(mulA, mulB[backendPkg::MUL_STEP-1:0]);
    assign busy = (state == uopPkg::MULBUSY);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= uopPkg::IDLE;
            stepCnt <= '0;
            wbValid <= 1'b0;
        end else begin
            wbValid <= 1'b0;
            case (state)
                uopPkg::IDLE: begin
                    if (startMul) begin
                        state <= uopPkg::MULBUSY;
                        stepCnt <= backendPkg::MulCount'(1);
                    end else if (start) begin
                        wbValid <= 1'b1;
                    end
                end
                uopPkg::MULBUSY: begin
                    stepCnt <= stepCnt + backendPkg::MulCount'(1);
                    if (stepCnt == backendPkg::MulCount'(backendPkg::MUL_CYCLES - 1)) begin
                        state <= uopPkg::IDLE;
                        wbValid <= 1'b1;
                    end
                end
                default: state <= uopPkg::IDLE;
            endcase
        end
    end

    // the issue cycle already folds in the lowest digit of the multiplier.
    always_ff @(posedge clk) begin
        if (state == uopPkg::IDLE && start) begin
            tagIdx <= issue.robIdx;
            tagRd <= issue.uop.rd;
            wb.robIdx <= issue.robIdx;
            wb.rd <= issue.uop.rd;
            wb.result <= aluCompute(issue.uop.op, issue.uop.srcA, issue.uop.srcB);
            acc <= stepProduct(issue.uop.srcA, issue.uop.srcB[backendPkg::MUL_STEP-1:0]);
            mulA <= issue.uop.srcA << backendPkg::MUL_STEP;
            mulB <= issue.uop.srcB >> backendPkg::MUL_STEP;
        end else if (busy) begin
            acc <= acc + partial;
            mulA <= mulA << backendPkg::MUL_STEP;
            mulB <= mulB >> backendPkg::MUL_STEP;
            wb.robIdx <= tagIdx;
            wb.rd <= tagRd;
            wb.result <= acc + partial;
        end
    end

endmodule

//--- ReorderBuffer.sv
`timescale 1ns/1ps

module ReorderBuffer (
    input  logic                clk,
    input  logic                rstN,
    input  logic                alloc,
    output backendPkg::RobIdx   allocIdx,
    output logic                full,
    input  backendPkg::LaneMask wbValid,
    input  uopPkg::WbBundle     wb [backendPkg::ALU_SIZE],
    output logic                commitValid,
    output uopPkg::CommitBundle commit
);

    logic [backendPkg::ROB_SIZE-1:0] done;
    backendPkg::RegIdx               rdMem [backendPkg::ROB_SIZE];
    backendPkg::Word                 valueMem [backendPkg::ROB_SIZE];
    backendPkg::RobIdx               head;
    backendPkg::RobIdx               tail;
    backendPkg::RobCount             count;

    assign allocIdx = tail;
    assign full = (count == backendPkg::RobCount'(backendPkg::ROB_SIZE));

    // the head retires as soon as its result is in.
    assign commitValid = done[head];
    assign commit.robIdx = head;
    assign commit.rd = rdMem[head];
    assign commit.value = valueMem[head];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (alloc) begin
                tail <= tail + backendPkg::RobIdx'(1);
            end
            if (commitValid) begin
                head <= head + backendPkg::RobIdx'(1);
            end
            case ({alloc, commitValid})
                2'b10:   count <= count + backendPkg::RobCount'(1);
                2'b01:   count <= count - backendPkg::RobCount'(1);
                default: count <= count;
            endcase
        end
    end

    // a lane never writes back to the entry that is leaving this cycle.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            done <= '0;
        end else begin
            if (commitValid) begin
                done[head] <= 1'b0;
            end
            for (int i = 0; i < backendPkg::ALU_SIZE; i++) begin
                if (wbValid[i]) begin
                    done[wb[i].robIdx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < backendPkg::ALU_SIZE; i++) begin
            if (wbValid[i]) begin
                rdMem[wb[i].robIdx] <= wb[i].rd;
                valueMem[wb[i].robIdx] <= wb[i].result;
            end
        end
    end

endmodule

//--- Backend.sv
`timescale 1ns/1ps

module Backend (
    input  logic                clk,
    input  logic                rstN,
    input  logic                uopValid,
    input  uopPkg::MicroOp      uop,
    output logic                stall,
    output logic                commitValid,
    output uopPkg::CommitBundle commit
);

    backendPkg::LaneMask laneBusy;
    backendPkg::LaneMask issueValid;
    backendPkg::LaneMask wbValid;
    backendPkg::RobIdx   allocIdx;
    logic                robFull;
    logic                alloc;
    uopPkg::IssueBundle  issue;
    uopPkg::WbBundle     wb [backendPkg::ALU_SIZE];

    Dispatch dispatch (
        .clk        (clk),
        .rstN       (rstN),
        .uopValid   (uopValid),
        .uop        (uop),
        .laneBusy   (laneBusy),
        .robFull    (robFull),
        .allocIdx   (allocIdx),
        .stall      (stall),
        .alloc      (alloc),
        .issueValid (issueValid),
        .issue      (issue)
    );

    // identical lanes, each one picks up the issue bundle on its own mask bit.
    for (genvar i = 0; i < backendPkg::ALU_SIZE; i++) begin : laneGen
        AluLane lane (
            .clk     (clk),
            .rstN    (rstN),
            .start   (issueValid[i]),
            .issue   (issue),
            .busy    (laneBusy[i]),
            .wbValid (wbValid[i]),
            .wb      (wb[i])
        );
    end

    ReorderBuffer rob (
        .clk         (clk),
        .rstN        (rstN),
        .alloc       (alloc),
        .allocIdx    (allocIdx),
        .full        (robFull),
        .wbValid     (wbValid),
        .wb          (wb),
        .commitValid (commitValid),
        .commit      (commit)
    );

endmodule

//--- tbBackend.sv
`timescale 1ns/1ps

module tbBackend;

    localparam int MAX_ROWS = 64;
    localparam int COLS = 5;
    localparam int RESET_CYCLES = 3;
    localparam int SETTLE_CYCLES = 5;
    localparam int CYCLES_PER_ROW = 40;
    localparam logic [31:0] SEED = 32'hb23b6e19;
    localparam logic [31:0] END_MARK = 32'h0000_00ff;

    // one outstanding micro-op with the row it came from.
    typedef struct packed {
        logic [31:0]       row;
        backendPkg::RegIdx rd;
        backendPkg::Word   value;
    } Expect;

    logic                clk;
    logic                rstN;
    logic                uopValid;
    uopPkg::MicroOp      uop;
    logic                stall;
    logic                commitValid;
    uopPkg::CommitBundle commit;

    logic [31:0] stimMem [MAX_ROWS*COLS];
    Expect       expectQ [$];
    int          rowCount;
    logic        loaded;

    // updated by the commit monitor only.
    int   commitCount = 0;
    int   commitPass = 0;
    int   commitFail = 0;
    logic stallSeen = 1'b0;

    int mainPass;
    int mainFail;

    Backend uut (
        .clk         (clk),
        .rstN        (rstN),
        .uopValid    (uopValid),
        .uop         (uop),
        .stall       (stall),
        .commitValid (commitValid),
        .commit      (commit)
    );

    always #2 clk = ~clk;

    // rows run up to the end marker in the op column.
    function automatic int countRows();
        int n;
        n = 0;
        while (n < MAX_ROWS && stimMem[n*COLS] != END_MARK) begin
            n++;
        end
        return n;
    endfunction

    function automatic logic isBurstMul(input int r);
        logic curMul;
        logic prevMul;
        if (r == 0) begin
            return 1'b0;
        end
        curMul = uopPkg::AluOp'(stimMem[r*COLS][2:0]) == uopPkg::MUL;
        prevMul = uopPkg::AluOp'(stimMem[(r-1)*COLS][2:0]) == uopPkg::MUL;
        return curMul && prevMul;
    endfunction

    function automatic void reportTest(input string name, input logic ok);
        $display("test %-14s %s", name, ok ? "pass" : "fail");
    endfunction

    // single-cycle strobe that waits out any stall.
    task automatic driveRow(input int r);
        int    base;
        Expect entry;
        base = r * COLS;
        while (stall) begin
            @(negedge clk);
        end
        uop.op = uopPkg::AluOp'(stimMem[base][2:0]);
        uop.rd = stimMem[base+1][4:0];
        uop.srcA = stimMem[base+2];
        uop.srcB = stimMem[base+3];
        uopValid = 1'b1;
        entry.row = r;
        entry.rd = uop.rd;
        entry.value = stimMem[base+4];
        expectQ.push_back(entry);
        @(negedge clk);
        uopValid = 1'b0;
    endtask

    // indices start at zero after reset and row r lands in r mod ROB_SIZE.
    task automatic checkCommit();
        Expect             entry;
        backendPkg::RobIdx wantIdx;
        logic              ok;
        commitCount++;
        ok = (expectQ.size() != 0);
        assert (ok) else begin
            $display("commit of robIdx %0d arrived with no micro-op outstanding", commit.robIdx);
        end
        if (!ok) begin
            commitFail++;
            reportTest("extra commit", 1'b0);
        end else begin
            entry = expectQ.pop_front();
            wantIdx = backendPkg::RobIdx'(entry.row % backendPkg::ROB_SIZE);
            ok = (commit.rd == entry.rd) && (commit.value == entry.value)
                && (commit.robIdx == wantIdx);
            assert (ok) else begin
                $display("FAIL %0t: row %0d got idx %0d rd %0d %h, want idx %0d rd %0d %h",
                    $time, entry.row, commit.robIdx, commit.rd, commit.value,
                    wantIdx, entry.rd, entry.value);
            end
            if (ok) begin
                commitPass++;
            end else begin
                commitFail++;
            end
            reportTest($sformatf("row %0d", entry.row), ok);
        end
    endtask

    always @(negedge clk) begin
        if (rstN) begin
            if (stall) begin
                stallSeen = 1'b1;
            end
            if (commitValid) begin
                checkCommit();
            end
        end
    end

    initial begin : mainSeq
        logic idleOk;
        logic countOk;
        int   gap;
        clk = 1'b0;
        rstN = 1'b0;
        uopValid = 1'b0;
        uop = '0;
        loaded = 1'b0;
        mainPass = 0;
        mainFail = 0;
        void'($urandom(SEED));
        $readmemh("backendStim.mem", stimMem);
        rowCount = countRows();
        loaded = 1'b1;
        $display("loaded %0d stimulus rows", rowCount);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        // nothing is strobed yet and the backend must sit idle.
        idleOk = 1'b1;
        for (int c = 0; c < SETTLE_CYCLES; c++) begin
            @(negedge clk);
            if (commitValid || stall) begin
                idleOk = 1'b0;
            end
        end
        assert (idleOk) else begin
            $display("FAIL %0t: commitValid or stall high before the first strobe", $time);
        end
        if (idleOk) begin
            mainPass++;
        end else begin
            mainFail++;
        end
        reportTest("reset idle", idleOk);

        // back-to-back MULs go without a gap so they pile up on the lanes.
        for (int r = 0; r < rowCount; r++) begin
            if (isBurstMul(r)) begin
                gap = 0;
            end else begin
                gap = int'($urandom % 4);
            end
            repeat (gap) @(negedge clk);
            driveRow(r);
        end

        while (commitCount < rowCount) begin
            @(negedge clk);
        end
        repeat (SETTLE_CYCLES) @(negedge clk);

        assert (stallSeen) else begin
            $display("FAIL %0t: stall never rose during the MUL burst", $time);
        end
        if (stallSeen) begin
            mainPass++;
        end else begin
            mainFail++;
        end
        reportTest("burst stall", stallSeen);

        countOk = (commitCount == rowCount) && (expectQ.size() == 0);
        assert (countOk) else begin
            $display("FAIL %0t: %0d commits for %0d rows", $time, commitCount, rowCount);
        end
        if (countOk) begin
            mainPass++;
        end else begin
            mainFail++;
        end
        reportTest("commit count", countOk);

        $display("%0d tests passed, %0d failed",
            mainPass + commitPass, mainFail + commitFail);
        if (mainFail + commitFail == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // one spare row of budget covers reset and the settling cycles.
    initial begin : watchdog
        wait (loaded);
        repeat ((rowCount + 1) * CYCLES_PER_ROW) @(posedge clk);
        $display("timeout: the micro-ops did not all commit within %0d cycles",
            (rowCount + 1) * CYCLES_PER_ROW);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

//--- backendStim.mem
// columns are op, rd, srcA, srcB and the expected result, all in hex.
// op codes are ADD 0, SUB 1, AND 2, OR 3, XOR 4, SLT 5, MUL 6, and op ff ends the table.
0 01 00000005 00000007 0000000c
1 02 00000010 00000003 0000000d
1 03 00000000 00000001 ffffffff
2 04 f0f0f0f0 ff00ff00 f000f000
3 05 f0f0f0f0 0f0f0000 fffff0f0
4 06 aaaaaaaa ffff0000 5555aaaa
5 07 ffffffff 00000001 00000001
5 08 00000001 ffffffff 00000000
5 09 80000000 7fffffff 00000001
5 0a 00000003 00000003 00000000
0 0b ffffffff 00000001 00000000
6 0c 00000003 00000007 00000015
6 0d 00010000 00010000 00000000
6 0e 12345678 00000010 23456780
6 0f ffffffff ffffffff 00000001
// a MUL overtaken by simple ops.
6 10 00001000 00000100 00100000
0 11 00000001 00000002 00000003
4 12 0000ffff 00000fff 0000f000
3 13 00000100 00000001 00000101
// burst of MULs, more than there are lanes.
6 14 00000002 00000003 00000006
6 15 00000100 00000100 00010000
6 16 deadbeef 00000001 deadbeef
6 17 00000000 12345678 00000000
6 18 0000ffff 0000ffff fffe0001
6 19 80000000 00000002 00000000
0 1a 7fffffff 00000001 80000000
1 1b 80000000 00000001 7fffffff
2 1c 12345678 0000ffff 00005678
4 1d 12345678 12345678 00000000
5 1e 80000000 00000000 00000001
5 1f 7fffffff 80000000 00000000
6 00 00000007 00000006 0000002a
0 01 00000064 000000c8 0000012c
6 02 01010101 01010101 04030201
3 03 00000000 00000000 00000000
ff 00 00000000 00000000 00000000

//--- sim.f
backendPkg.sv
uopPkg.sv
Dispatch.sv
AluLane.sv
ReorderBuffer.sv
Backend.sv
tbBackend.sv

//--- Makefile
# Verilator flow for the out-of-order backend testbench.

VERILATOR ?= verilator
TOP       ?= tbBackend
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
